// File: logic/vend_pkg.sv
package vend_pkg;

    typedef enum logic [1:0] {
        coin_none    = 2'd0, // no coin or unreadable
        coin_nickel  = 2'd1,
        coin_dime    = 2'd2,
        coin_quarter = 2'd3
    } coin_t;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_credit = 2'd1,
        st_vend   = 2'd2,
        st_change = 2'd3
    } vend_state_t;

    localparam int cents_w = 6; // 20 + 25 fits
    localparam logic [cents_w-1:0] price_cents = 6'd25;
    localparam int hold_cycles = 16; // per message on the display
    localparam int queue_depth = 4;

    // active low with segment a in the msb through g in the lsb
    localparam logic [6:0] glyph_blank = 7'b111_1111;
    localparam logic [6:0] glyph_0     = 7'b000_0001;
    localparam logic [6:0] glyph_1     = 7'b100_1111;
    localparam logic [6:0] glyph_2     = 7'b001_0010;
    localparam logic [6:0] glyph_3     = 7'b000_0110;
    localparam logic [6:0] glyph_4     = 7'b100_1100;
    localparam logic [6:0] glyph_5     = 7'b010_0100;
    localparam logic [6:0] glyph_6     = 7'b010_0000;
    localparam logic [6:0] glyph_7     = 7'b000_1111;
    localparam logic [6:0] glyph_8     = 7'b000_0000;
    localparam logic [6:0] glyph_9     = 7'b000_0100;
    localparam logic [6:0] glyph_b     = 7'b110_0000;
    localparam logic [6:0] glyph_u     = 7'b110_0011;
    localparam logic [6:0] glyph_y     = 7'b100_0100;
    localparam logic [6:0] glyph_n     = 7'b110_1010;
    localparam logic [6:0] glyph_j     = 7'b100_0011;
    localparam logic [6:0] glyph_o     = 7'b110_0010;
    localparam logic [6:0] glyph_c     = 7'b011_0001;
    localparam logic [6:0] glyph_h     = 7'b110_1000;

endpackage

// File: logic/coin_intake.sv
`timescale 1ns/1ns

module coin_intake (
    input  logic            clk,
    input  logic            reset,
    input  logic            coin_level,
    input  vend_pkg::coin_t coin_kind,
    input  logic            full,
    output logic            wr_en,
    output vend_pkg::coin_t wr_kind,
    output logic            coin_reject
);

    logic level_meta;
    logic level_sync;
    logic level_prev;
    logic rise;
    logic kind_bad;

    assign rise     = level_sync && !level_prev;
    assign kind_bad = (coin_kind == vend_pkg::coin_none);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level_meta  <= 1'b0;
            level_sync  <= 1'b0;
            level_prev  <= 1'b0;
            wr_en       <= 1'b0;
            coin_reject <= 1'b0;
        end else begin
            level_meta  <= coin_level; // sensor is asynchronous
            level_sync  <= level_meta;
            level_prev  <= level_sync;
            wr_en       <= rise && !kind_bad && !full;
            coin_reject <= rise && (kind_bad || full); // no room counts as a reject too
        end
    end

    // kind is settled well before the level edge gets through the flops
    always_ff @(posedge clk) begin
        if (rise) begin
            wr_kind <= coin_kind;
        end
    end

endmodule

// File: logic/coin_queue.sv
`timescale 1ns/1ns

module coin_queue (
    input  logic            clk,
    input  logic            reset,
    input  logic            wr_en,
    input  vend_pkg::coin_t wr_kind,
    output logic            full,
    output logic            coin_req,
    output vend_pkg::coin_t coin_kind_out,
    input  logic            coin_ack
);

    vend_pkg::coin_t mem [vend_pkg::queue_depth];

    logic [$clog2(vend_pkg::queue_depth)-1:0]   wr_ptr;
    logic [$clog2(vend_pkg::queue_depth)-1:0]   rd_ptr;
    logic [$clog2(vend_pkg::queue_depth+1)-1:0] count;
    logic push;
    logic pop;

    assign full          = (count == $bits(count)'(vend_pkg::queue_depth));
    assign push          = wr_en && !full;
    assign pop           = coin_req && coin_ack; // consumer has latched the head
    assign coin_kind_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_kind;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            coin_req <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // re-arm only once ack is back low
            if (pop) begin
                coin_req <= 1'b0;
            end else if (!coin_req && !coin_ack && count != '0) begin
                coin_req <= 1'b1;
            end
        end
    end

    a_kind_stable: assert property (
        @(posedge clk) disable iff (reset)
        coin_req && $past(coin_req) |-> $stable(coin_kind_out)
    ) else $error("coin_kind_out changed while coin_req high");

    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !full
    ) else $error("write into full coin queue");

endmodule

// File: logic/vend_fsm.sv
`timescale 1ns/1ns

module vend_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          coin_req,
    input  vend_pkg::coin_t               coin_kind,
    output logic                          coin_ack,
    output vend_pkg::vend_state_t         state,
    output logic [vend_pkg::cents_w-1:0]  credit_cents,
    output logic [vend_pkg::cents_w-1:0]  change_cents,
    output logic                          vend
);

    logic [$clog2(vend_pkg::hold_cycles)-1:0] hold_cnt;
    logic [vend_pkg::cents_w-1:0] coin_value;
    logic [vend_pkg::cents_w-1:0] new_credit;
    logic accepting;
    logic take_coin;
    logic hold_done;

    always_comb begin
        case (coin_kind)
            vend_pkg::coin_nickel:  coin_value = vend_pkg::cents_w'(5);
            vend_pkg::coin_dime:    coin_value = vend_pkg::cents_w'(10);
            vend_pkg::coin_quarter: coin_value = vend_pkg::cents_w'(25);
            default:                coin_value = '0; // never queued
        endcase
    end

    assign new_credit = credit_cents + coin_value;
    assign accepting  = (state == vend_pkg::st_idle) || (state == vend_pkg::st_credit);
    assign take_coin  = coin_req && !coin_ack && accepting; // back-pressure otherwise
    assign hold_done  = (hold_cnt == $bits(hold_cnt)'(vend_pkg::hold_cycles - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= vend_pkg::st_idle;
            coin_ack     <= 1'b0;
            credit_cents <= '0;
            change_cents <= '0;
            vend         <= 1'b0;
            hold_cnt     <= '0;
        end else begin
            vend <= 1'b0;

            if (coin_ack) begin
                coin_ack <= coin_req; // drop once req has gone low
            end else if (take_coin) begin
                coin_ack <= 1'b1;
            end

            case (state)
                vend_pkg::st_idle,
                vend_pkg::st_credit: begin
                    hold_cnt <= '0;
                    if (take_coin) begin
                        if (new_credit >= vend_pkg::price_cents) begin
                            state        <= vend_pkg::st_vend;
                            vend         <= 1'b1;
                            change_cents <= new_credit - vend_pkg::price_cents;
                            credit_cents <= '0;
                        end else begin
                            state        <= vend_pkg::st_credit;
                            credit_cents <= new_credit;
                        end
                    end
                end
                vend_pkg::st_vend: begin
                    if (hold_done) begin
                        hold_cnt <= '0;
                        state    <= (change_cents != '0) ? vend_pkg::st_change
                                                         : vend_pkg::st_idle;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: begin // st_change
                    if (hold_done) begin
                        hold_cnt <= '0;
                        state    <= vend_pkg::st_idle;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(coin_ack) |-> $past(coin_req)
    ) else $error("coin_ack rose without a pending coin_req");

endmodule

// File: logic/seg7_control.sv
`timescale 1ns/1ns

module seg7_control #(
    parameter int scan_div = 100000 // cycles per digit
) (
    input  logic                         clk,
    input  logic                         reset,
    input  vend_pkg::vend_state_t        state,
    input  logic [vend_pkg::cents_w-1:0] credit_cents,
    input  logic [vend_pkg::cents_w-1:0] change_cents,
    output logic [0:6]                   seg,
    output logic [3:0]                   an
);

    logic [$clog2(scan_div+1)-1:0] scan_timer;
    logic [1:0] digit_idx;
    logic [vend_pkg::cents_w-1:0] shown;
    logic [3:0] tens;
    logic [3:0] units;
    logic [6:0] tens_glyph;
    logic [6:0] next_seg;

    function automatic logic [6:0] digit_glyph(input logic [3:0] d);
        case (d)
            4'd0:    return vend_pkg::glyph_0;
            4'd1:    return vend_pkg::glyph_1;
            4'd2:    return vend_pkg::glyph_2;
            4'd3:    return vend_pkg::glyph_3;
            4'd4:    return vend_pkg::glyph_4;
            4'd5:    return vend_pkg::glyph_5;
            4'd6:    return vend_pkg::glyph_6;
            4'd7:    return vend_pkg::glyph_7;
            4'd8:    return vend_pkg::glyph_8;
            4'd9:    return vend_pkg::glyph_9;
            default: return vend_pkg::glyph_blank;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_timer <= '0;
            digit_idx  <= 2'd0;
        end else if (scan_timer == $bits(scan_timer)'(scan_div - 1)) begin
            scan_timer <= '0;
            digit_idx  <= digit_idx + 2'd1;
        end else begin
            scan_timer <= scan_timer + 1'b1;
        end
    end

    always_comb begin
        case (digit_idx)
            2'd0:    an = 4'b0111; // leftmost
            2'd1:    an = 4'b1011;
            2'd2:    an = 4'b1101;
            default: an = 4'b1110;
        endcase
    end

    assign shown      = (state == vend_pkg::st_change) ? change_cents : credit_cents;
    assign tens       = 4'(shown / 10);
    assign units      = 4'(shown % 10);
    assign tens_glyph = (tens == 4'd0) ? vend_pkg::glyph_blank : digit_glyph(tens);

    always_comb begin
        next_seg = vend_pkg::glyph_blank;
        case (state)
            vend_pkg::st_idle: begin
                case (digit_idx)
                    2'd1:    next_seg = vend_pkg::glyph_b;
                    2'd2:    next_seg = vend_pkg::glyph_u;
                    2'd3:    next_seg = vend_pkg::glyph_y;
                    default: next_seg = vend_pkg::glyph_blank;
                endcase
            end
            vend_pkg::st_credit: begin
                case (digit_idx)
                    2'd1:    next_seg = tens_glyph;
                    2'd2:    next_seg = digit_glyph(units);
                    default: next_seg = vend_pkg::glyph_blank;
                endcase
            end
            vend_pkg::st_vend: begin
                case (digit_idx)
                    2'd0:    next_seg = vend_pkg::glyph_n;
                    2'd1:    next_seg = vend_pkg::glyph_j;
                    2'd2:    next_seg = vend_pkg::glyph_o;
                    default: next_seg = vend_pkg::glyph_y;
                endcase
            end
            default: begin // st_change with tens and units on the right
                case (digit_idx)
                    2'd0:    next_seg = vend_pkg::glyph_c;
                    2'd1:    next_seg = vend_pkg::glyph_h;
                    2'd2:    next_seg = tens_glyph;
                    default: next_seg = digit_glyph(units);
                endcase
            end
        endcase
    end

    always_ff @(posedge clk) begin
        seg <= next_seg; // one cycle behind an
    end

    a_one_anode: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(~an)
    ) else $error("anode select not one-hot low");

endmodule

// File: logic/vending_top.sv
`timescale 1ns/1ns

module vending_top #(
    parameter int scan_div = 100000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         coin_level,
    input  vend_pkg::coin_t              coin_kind,
    output logic                         coin_reject,
    output logic                         vend,
    output logic [vend_pkg::cents_w-1:0] change_cents,
    output logic [0:6]                   seg,
    output logic [3:0]                   an
);

    logic                         wr_en;
    vend_pkg::coin_t              wr_kind;
    logic                         full;
    logic                         coin_req;
    vend_pkg::coin_t              coin_kind_q;
    logic                         coin_ack;
    vend_pkg::vend_state_t        state;
    logic [vend_pkg::cents_w-1:0] credit_cents;

    coin_intake coin_intake_i (
        .clk         (clk),
        .reset       (reset),
        .coin_level  (coin_level),
        .coin_kind   (coin_kind),
        .full        (full),
        .wr_en       (wr_en),
        .wr_kind     (wr_kind),
        .coin_reject (coin_reject)
    );

    coin_queue coin_queue_i (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_kind       (wr_kind),
        .full          (full),
        .coin_req      (coin_req),
        .coin_kind_out (coin_kind_q),
        .coin_ack      (coin_ack)
    );

    vend_fsm vend_fsm_i (
        .clk          (clk),
        .reset        (reset),
        .coin_req     (coin_req),
        .coin_kind    (coin_kind_q),
        .coin_ack     (coin_ack),
        .state        (state),
        .credit_cents (credit_cents),
        .change_cents (change_cents),
        .vend         (vend)
    );

    seg7_control #(
        .scan_div (scan_div)
    ) seg7_control_i (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .credit_cents (credit_cents),
        .change_cents (change_cents),
        .seg          (seg),
        .an           (an)
    );

endmodule

// File: tb/vending_tb.sv
`timescale 1ns/1ns

module vending_tb;

    localparam int hold = vend_pkg::hold_cycles;

    logic                         clk;
    logic                         reset;
    logic                         coin_level;
    vend_pkg::coin_t              coin_kind;
    logic                         coin_reject;
    logic                         vend;
    logic [vend_pkg::cents_w-1:0] change_cents;
    logic [0:6]                   seg;
    logic [3:0]                   an;

    logic [31:0] rng_state = 32'he6bfe4b9;
    logic [6:0]  shown [4];
    logic [3:0]  prev_an = 4'b0111;
    int exp_change [$];
    int errors = 0;
    int checks = 0;
    int timeouts = 0;
    int cyc = 0;
    int last_vend_cyc = -1000;
    int vend_age = 1000;
    int vend_change = 0;
    int vend_count = 0;
    int reject_pulses = 0;
    int model_credit = 0;
    int model_vends = 0;
    int sent = 0;
    int accepted = 0;

    vending_top #(.scan_div(4)) vending_top_i (
        .clk          (clk),
        .reset        (reset),
        .coin_level   (coin_level),
        .coin_kind    (coin_kind),
        .coin_reject  (coin_reject),
        .vend         (vend),
        .change_cents (change_cents),
        .seg          (seg),
        .an           (an)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int digit_of(input logic [3:0] a);
        case (a)
            4'b0111: return 0; // leftmost digit
            4'b1011: return 1;
            4'b1101: return 2;
            4'b1110: return 3;
            default: return -1;
        endcase
    endfunction

    function automatic logic [6:0] glyph_of_digit(input int d);
        case (d)
            0: return vend_pkg::glyph_0;
            1: return vend_pkg::glyph_1;
            2: return vend_pkg::glyph_2;
            3: return vend_pkg::glyph_3;
            4: return vend_pkg::glyph_4;
            5: return vend_pkg::glyph_5;
            6: return vend_pkg::glyph_6;
            7: return vend_pkg::glyph_7;
            8: return vend_pkg::glyph_8;
            default: return vend_pkg::glyph_9;
        endcase
    endfunction

    // what each digit should show for a display mode and a cents value
    function automatic logic [6:0] expected_glyph(input vend_pkg::vend_state_t mode,
                                                  input int idx, input int cents);
        logic [6:0] tens_g;
        tens_g = (cents / 10 == 0) ? vend_pkg::glyph_blank : glyph_of_digit(cents / 10);
        case (mode)
            vend_pkg::st_idle: begin
                if (idx == 1) return vend_pkg::glyph_b;
                if (idx == 2) return vend_pkg::glyph_u;
                if (idx == 3) return vend_pkg::glyph_y;
                return vend_pkg::glyph_blank;
            end
            vend_pkg::st_credit: begin
                if (idx == 1) return tens_g;
                if (idx == 2) return glyph_of_digit(cents % 10);
                return vend_pkg::glyph_blank;
            end
            vend_pkg::st_vend: begin
                if (idx == 0) return vend_pkg::glyph_n;
                if (idx == 1) return vend_pkg::glyph_j;
                if (idx == 2) return vend_pkg::glyph_o;
                return vend_pkg::glyph_y;
            end
            default: begin
                if (idx == 0) return vend_pkg::glyph_c;
                if (idx == 1) return vend_pkg::glyph_h;
                if (idx == 2) return tens_g;
                return glyph_of_digit(cents % 10);
            end
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("Fail at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        end
    endtask

    // seg lags an by one cycle, so seg at this edge belongs to prev_an
    always @(negedge clk) begin
        int idx;
        if (!reset) begin
            if (vend) begin
                vend_count++;
                vend_age = 0;
                last_vend_cyc = cyc;
                if (exp_change.size() == 0) begin
                    errors++;
                    vend_change = 0;
                    $display("a vend pulse came with no vend predicted at %0t", $time);
                end else begin
                    vend_change = exp_change.pop_front();
                    check_value("change_cents", vend_change, int'(change_cents));
                end
            end else if (vend_age < 1000) begin
                vend_age++;
            end
            if (coin_reject) reject_pulses++;
            idx = digit_of(prev_an);
            if (idx >= 0 && vend_age >= 2 && vend_age < hold) begin
                check_value("seg while vending",
                            int'(expected_glyph(vend_pkg::st_vend, idx, 0)), int'(seg));
            end else if (idx >= 0 && vend_change != 0 && vend_age >= hold + 2
                         && vend_age < 2 * hold) begin
                check_value("seg while showing change",
                            int'(expected_glyph(vend_pkg::st_change, idx, vend_change)), int'(seg));
            end
        end
        prev_an = an;
    end

    task automatic capture_digits();
        logic [3:0] last_an;
        int idx;
        int got;
        int waited;
        got = 0;
        waited = 0;
        @(negedge clk);
        last_an = an;
        while (got != 15 && waited < 100) begin
            @(negedge clk);
            waited++;
            if (an != last_an) begin
                idx = digit_of(an);
                last_an = an;
                @(negedge clk); // seg catches up one cycle later
                waited++;
                if (idx >= 0) begin
                    shown[idx] = seg;
                    got |= 1 << idx;
                end
            end
        end
        if (got != 15) begin
            errors++;
            timeouts++;
            $display("the display scan did not reach all four digits in time");
        end
    endtask

    task automatic check_display(input vend_pkg::vend_state_t mode, input int cents);
        capture_digits();
        for (int i = 0; i < 4; i++) begin
            check_value($sformatf("seg digit %0d", i),
                        int'(expected_glyph(mode, i, cents)), int'(shown[i]));
        end
    endtask

    // queue drained and no vend or change message running
    task automatic wait_quiet();
        int start;
        int waited;
        start = cyc;
        waited = 0;
        while (((cyc - last_vend_cyc) < 5 * hold || (cyc - start) < 5 * hold) && waited < 1000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 1000) begin
            errors++;
            timeouts++;
            $display("the controller never went quiet after the last coin");
        end
    endtask

    task automatic send_coin(input vend_pkg::coin_t kind);
        logic rejected;
        int value;
        rejected = 1'b0;
        @(posedge clk);
        coin_kind  <= kind;
        coin_level <= 1'b1;
        sent++;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (coin_reject) rejected = 1'b1;
        end
        if (kind == vend_pkg::coin_none) check_value("coin_reject", 1, int'(rejected));
        if (!rejected) begin
            accepted++;
            value = (kind == vend_pkg::coin_nickel) ? 5 : (kind == vend_pkg::coin_dime) ? 10 : 25;
            model_credit += value;
            if (model_credit >= 25) begin
                exp_change.push_back(model_credit - 25);
                model_vends++;
                model_credit = 0;
            end
        end
        @(posedge clk);
        coin_level <= 1'b0;
        if (rejected && kind != vend_pkg::coin_none && vend_age >= 3 * hold) begin
            errors++;
            $display("a valid coin was rejected at %0t while the queue had drained", $time);
        end
    endtask

    initial begin
        logic [31:0] r;
        vend_pkg::coin_t kind;
        reset      = 1'b1;
        coin_level = 1'b0;
        coin_kind  = vend_pkg::coin_none;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        check_display(vend_pkg::st_idle, 0);

        for (int n = 0; n < 80; n++) begin
            r = next_rand();
            case (r[31:29])
                3'd0:                kind = vend_pkg::coin_none; // about one in eight
                3'd1, 3'd2, 3'd3:    kind = vend_pkg::coin_nickel;
                3'd4, 3'd5:          kind = vend_pkg::coin_dime;
                default:             kind = vend_pkg::coin_quarter;
            endcase
            send_coin(kind);
            r = next_rand();
            if (r[31:30] == 2'd0) begin
                wait_quiet();
                check_display((model_credit == 0) ? vend_pkg::st_idle : vend_pkg::st_credit,
                              model_credit);
            end else begin
                repeat (3 + int'(r[26:24])) @(posedge clk); // short gaps pile coins up
            end
        end

        wait_quiet();
        check_value("vend count", model_vends, vend_count);
        check_value("coins sent", sent, accepted + reject_pulses);
        check_value("vends still predicted", 0, exp_change.size());
        $display("checks %0d, errors %0d, timeouts %0d, coins %0d, accepted %0d, vends %0d",
                 checks, errors, timeouts, sent, accepted, vend_count);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/vend_pkg.sv
logic/coin_intake.sv
logic/coin_queue.sv
logic/vend_fsm.sv
logic/seg7_control.sv
logic/vending_top.sv
tb/vending_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the vending testbench with Verilator, logs go to build.log and sim.log

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module vending_tb -o vending_sim \
    > build.log 2>&1 &&
./obj_dir/vending_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Regression failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
